//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it, the exit status carries pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f verilog.f --top-module assoc_cache_tb \
	&& ./obj_dir/Vassoc_cache_tb \
	|| exit 1

//--- verification/assoc_cache_checker.sv
`include "cache_defines.svh"

module assoc_cache_checker (
	input logic                         clk,
	input logic                         rst_n,
	input cache_ctrl_pkg::cache_state_e state,
	input logic                         ready,
	input logic                         fetch_req,
	input logic                         evict_valid,
	input logic                         evict_ack
);
	import cache_ctrl_pkg::*;

	// the backing store only ever sees one open request
	no_overlap_a: assert property (@(posedge clk) disable iff (!rst_n)
		!(fetch_req && evict_valid))
		else $error("fetch_req and evict_valid are high in the same cycle");

	// a scan spends one cycle on each line before the victim is offered
	scan_len_a: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(state == st_scan) |->
			##(`CACHE_LINES - 1) (state == st_scan) ##1 (state == st_unload))
		else $error("the victim scan did not take one cycle per line");

	// an offered victim stays offered until the store takes it
	evict_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
		(evict_valid && !evict_ack) |=> evict_valid)
		else $error("evict_valid dropped before evict_ack");

endmodule

bind cache_ctrl assoc_cache_checker checker_i (
	.clk         (clk),
	.rst_n       (rst_n),
	.state       (state),
	.ready       (ready),
	.fetch_req   (fetch_req),
	.evict_valid (evict_valid),
	.evict_ack   (evict_ack)
);

//--- verification/assoc_cache_tb.sv
`include "cache_defines.svh"

module assoc_cache_tb;
	import cache_types_pkg::*;
	import cache_ctrl_pkg::*;

	localparam int wait_limit = 100;	// cycles allowed for any single wait

	logic      clk;
	logic      rst_n;
	logic      req;
	cache_op_e op;
	addr_t     addr;
	data_t     wdata;
	logic      ready;
	data_t     rdata;
	logic      fetch_req;
	addr_t     fetch_addr;
	logic      fetch_valid;
	data_t     fetch_data;
	logic      evict_valid;
	addr_t     evict_addr;
	data_t     evict_data;
	logic      evict_ack;

	data_t store_mem [2**`CACHE_ADDR_W];	// backing store contents
	data_t truth [2**`CACHE_ADDR_W];	// latest value the host should see per address
	addr_t lru_q [$];	// cached addresses, least recently accessed first
	addr_t evict_addr_log [$];
	data_t evict_data_log [$];

	logic [31:0] lfsr;
	int          delay_base;	// added to every store answer delay
	int          fetch_count;
	int          evict_count;
	int          fetch_wait;
	int          evict_wait;
	logic        fetch_armed;
	logic        evict_armed;

	assoc_cache dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.op          (op),
		.addr        (addr),
		.wdata       (wdata),
		.ready       (ready),
		.rdata       (rdata),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.fetch_valid (fetch_valid),
		.fetch_data  (fetch_data),
		.evict_valid (evict_valid),
		.evict_addr  (evict_addr),
		.evict_data  (evict_data),
		.evict_ack   (evict_ack)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	function automatic data_t store_pattern(input addr_t a);
		return {a ^ 8'h5a, ~a};
	endfunction

	// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
	function automatic logic [7:0] draw_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic fail(input string msg);
		$display("%s at time %0t", msg, $time);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR: time %0t, %s: got %0h, expected %0h", $time, name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// the store model answers each open request after a random delay
	initial begin
		fetch_valid = 1'b0;
		fetch_data  = '0;
		evict_ack   = 1'b0;
		fetch_armed = 1'b0;
		evict_armed = 1'b0;
		forever begin
			@(negedge clk);
			if (fetch_valid) begin
				fetch_valid = 1'b0;
			end else if (fetch_req) begin
				if (!fetch_armed) begin
					fetch_wait  = delay_base + int'(draw_bits(2));
					fetch_armed = 1'b1;
				end
				if (fetch_wait == 0) begin
					fetch_valid = 1'b1;
					fetch_data  = store_mem[fetch_addr];
					fetch_armed = 1'b0;
					fetch_count++;
				end else begin
					fetch_wait--;
				end
			end
			if (evict_ack) begin
				evict_ack = 1'b0;
			end else if (evict_valid) begin
				if (!evict_armed) begin
					evict_wait  = delay_base + int'(draw_bits(2));
					evict_armed = 1'b1;
				end
				if (evict_wait == 0) begin
					evict_ack = 1'b1;
					store_mem[evict_addr] = evict_data;	// every victim is written back
					evict_addr_log.push_back(evict_addr);
					evict_data_log.push_back(evict_data);
					evict_armed = 1'b0;
					evict_count++;
				end else begin
					evict_wait--;
				end
			end
		end
	end

	task automatic start_req(input cache_op_e o, input addr_t a, input data_t d);
		@(negedge clk);
		req   = 1'b1;
		op    = o;
		addr  = a;
		wdata = d;
		#1;
	endtask

	task automatic end_req();
		@(negedge clk);
		req = 1'b0;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!ready) begin
			if (n == wait_limit) fail("timed out waiting for ready");
			@(negedge clk);
			#1;
			n++;
		end
	endtask

	task automatic wait_fetch();
		int n;
		n = 0;
		while (!fetch_req) begin
			if (ready) fail("ready rose before the fetch completed");
			if (n == wait_limit) fail("timed out waiting for fetch_req");
			@(negedge clk);
			#1;
			n++;
		end
	endtask

	task automatic wait_evict();
		int n;
		n = 0;
		while (!evict_valid) begin
			if (ready) fail("ready rose before the eviction completed");
			if (n == wait_limit) fail("timed out waiting for evict_valid");
			@(negedge clk);
			#1;
			n++;
		end
	endtask

	// one host access is checked against a least recently accessed reference
	task automatic access(input cache_op_e o, input addr_t a, input data_t d);
		int    hit_pos;
		logic  exp_evict;
		addr_t victim;
		int    fetch_before;
		int    evict_before;
		hit_pos   = -1;
		exp_evict = 1'b0;
		victim    = '0;
		for (int i = 0; i < lru_q.size(); i++) begin
			if (lru_q[i] == a) hit_pos = i;
		end
		if (hit_pos < 0 && lru_q.size() == `CACHE_LINES) begin
			exp_evict = 1'b1;
			victim    = lru_q[0];
		end
		fetch_before = fetch_count;
		evict_before = evict_count;
		start_req(o, a, d);
		if (hit_pos < 0) begin
			if (exp_evict) begin
				wait_evict();
				check("evict_addr", 32'(evict_addr), 32'(victim));
				check("evict_data", 32'(evict_data), 32'(truth[victim]));
			end
			wait_fetch();
			check("fetch_addr", 32'(fetch_addr), 32'(a));
		end
		wait_ready();
		if (o == op_read) check("rdata", 32'(rdata), 32'(truth[a]));
		check("fetch count", fetch_count, fetch_before + ((hit_pos < 0) ? 1 : 0));
		check("evict count", evict_count, evict_before + (exp_evict ? 1 : 0));
		end_req();
		if (hit_pos >= 0) begin
			lru_q.delete(hit_pos);
		end else if (exp_evict) begin
			void'(lru_q.pop_front());
		end
		lru_q.push_back(a);
		if (o == op_write) truth[a] = d;
	endtask

	task automatic test_cold_read();
		access(op_read, 8'h10, '0);
	endtask

	task automatic test_write_read_hit();
		access(op_write, 8'h10, 16'hbeef);
		access(op_read, 8'h10, '0);
	endtask

	task automatic test_fill_no_evict();
		int evict_before;
		evict_before = evict_count;
		access(op_read, 8'h21, '0);
		access(op_read, 8'h32, '0);
		access(op_read, 8'h43, '0);
		check("evict count", evict_count, evict_before);
	endtask

	// line 0x10 ends up least recently accessed and carries the earlier write
	task automatic test_lru_eviction();
		access(op_read, 8'h43, '0);
		access(op_read, 8'h21, '0);
		access(op_write, 8'h32, 16'h1234);
		access(op_read, 8'h54, '0);
		check("evicted address", 32'(evict_addr_log[$]), 32'h10);
		check("evicted data", 32'(evict_data_log[$]), 32'hbeef);
	endtask

	task automatic test_refetch();
		access(op_read, 8'h10, '0);
	endtask

	task automatic test_back_pressure();
		delay_base = 20;
		access(op_write, 8'h65, 16'h5555);
		access(op_read, 8'h21, '0);
		delay_base = 0;
	endtask

	initial begin
		rst_n       = 1'b0;
		req         = 1'b0;
		op          = op_read;
		addr        = '0;
		wdata       = '0;
		lfsr        = 32'hc0e0;
		delay_base  = 0;
		fetch_count = 0;
		evict_count = 0;
		for (int i = 0; i < 2**`CACHE_ADDR_W; i++) begin
			store_mem[addr_t'(i)] = store_pattern(addr_t'(i));
			truth[addr_t'(i)]     = store_pattern(addr_t'(i));
		end
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		#1;
		check("ready", 32'(ready), 32'h0);
		check("fetch_req", 32'(fetch_req), 32'h0);
		check("evict_valid", 32'(evict_valid), 32'h0);
		test_cold_read();
		test_write_read_hit();
		test_fill_no_evict();
		test_lru_eviction();
		test_refetch();
		test_back_pressure();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+verilog
verilog/cache_types_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/line_store.sv
verilog/age_tracker.sv
verilog/victim_scan.sv
verilog/cache_ctrl.sv
verilog/assoc_cache.sv
verification/assoc_cache_checker.sv
verification/assoc_cache_tb.sv

//--- verilog/age_tracker.sv
`include "cache_defines.svh"

module age_tracker (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       touch,
	input  cache_types_pkg::line_idx_t touch_idx,
	output cache_types_pkg::age_vec_t  ages
);
	import cache_types_pkg::*;

	// every counter drains by one per cycle and sticks at zero
	// a touched line jumps back to the top of the range
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ages <= '0;
		end else begin
			for (int i = 0; i < `CACHE_LINES; i++) begin
				if (touch && (touch_idx == line_idx_t'(i))) begin
					ages[i] <= '1;
				end else if (ages[i] != '0) begin
					ages[i] <= ages[i] - 1'b1;
				end
			end
		end
	end

endmodule

//--- verilog/assoc_cache.sv
module assoc_cache (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      req,
	input  cache_ctrl_pkg::cache_op_e op,
	input  cache_types_pkg::addr_t    addr,
	input  cache_types_pkg::data_t    wdata,
	output logic                      ready,
	output cache_types_pkg::data_t    rdata,
	output logic                      fetch_req,
	output cache_types_pkg::addr_t    fetch_addr,
	input  logic                      fetch_valid,
	input  cache_types_pkg::data_t    fetch_data,
	output logic                      evict_valid,
	output cache_types_pkg::addr_t    evict_addr,
	output cache_types_pkg::data_t    evict_data,
	input  logic                      evict_ack
);
	import cache_types_pkg::*;

	logic      hit;
	logic      has_free;
	logic      scan_done;
	logic      touch;
	logic      wr_en;
	logic      fill_en;
	logic      inval_en;
	logic      scan_start;
	line_idx_t hit_idx;
	line_idx_t free_idx;
	line_idx_t victim_idx;
	line_idx_t touch_idx;
	age_vec_t  ages;

	// the host holds addr for the whole miss, so it doubles as the fetch address
	assign fetch_addr = addr;
	assign touch_idx  = fill_en ? free_idx : hit_idx;

	cache_ctrl ctrl_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.op          (op),
		.hit         (hit),
		.has_free    (has_free),
		.scan_done   (scan_done),
		.fetch_valid (fetch_valid),
		.evict_ack   (evict_ack),
		.ready       (ready),
		.touch       (touch),
		.wr_en       (wr_en),
		.fill_en     (fill_en),
		.inval_en    (inval_en),
		.scan_start  (scan_start),
		.fetch_req   (fetch_req),
		.evict_valid (evict_valid)
	);

	line_store store_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.lookup_addr (addr),
		.wdata       (wdata),
		.fill_data   (fetch_data),
		.wr_en       (wr_en),
		.fill_en     (fill_en),
		.inval_en    (inval_en),
		.victim_idx  (victim_idx),
		.hit         (hit),
		.hit_idx     (hit_idx),
		.rdata       (rdata),
		.has_free    (has_free),
		.free_idx    (free_idx),
		.victim_addr (evict_addr),
		.victim_data (evict_data)
	);

	age_tracker ages_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.touch     (touch),
		.touch_idx (touch_idx),
		.ages      (ages)
	);

	victim_scan scan_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.scan_start (scan_start),
		.ages       (ages),
		.victim_idx (victim_idx),
		.scan_done  (scan_done)
	);

endmodule

//--- verilog/cache_ctrl.sv
module cache_ctrl (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      req,
	input  cache_ctrl_pkg::cache_op_e op,
	input  logic                      hit,
	input  logic                      has_free,
	input  logic                      scan_done,
	input  logic                      fetch_valid,
	input  logic                      evict_ack,
	output logic                      ready,
	output logic                      touch,
	output logic                      wr_en,
	output logic                      fill_en,
	output logic                      inval_en,
	output logic                      scan_start,
	output logic                      fetch_req,
	output logic                      evict_valid
);
	import cache_ctrl_pkg::*;

	cache_state_e state;
	cache_state_e state_nxt;

	logic idle;
	logic miss;

	assign idle = (state == st_idle);
	assign miss = idle && req && !hit;

	// hits are answered in the same cycle as the request
	assign ready = idle && req && hit;
	assign wr_en = ready && (op == op_write);

	assign fill_en    = (state == st_fetch) && fetch_valid;
	assign inval_en   = (state == st_unload) && evict_ack;
	assign scan_start = miss && !has_free;

	// a fill counts as an access, so the new line starts out youngest
	assign touch = ready || fill_en;

	assign fetch_req   = (state == st_fetch);
	assign evict_valid = (state == st_unload);

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (miss) begin
					state_nxt = has_free ? st_fetch : st_scan;
				end
			end
			st_scan: begin
				if (scan_done) begin
					state_nxt = st_unload;
				end
			end
			st_unload: begin
				if (evict_ack) begin
					state_nxt = st_fetch;	// the vacated line is now the free one
				end
			end
			st_fetch: begin
				if (fetch_valid) begin
					state_nxt = st_idle;
				end
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

//--- verilog/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

	// host access kind
	typedef enum logic {
		op_read,
		op_write
	} cache_op_e;

	// controller FSM states
	typedef enum logic [1:0] {
		st_idle,	// serving hits, decoding misses
		st_scan,	// walking all lines for the least used one
		st_unload,	// victim offered to the backing store
		st_fetch	// waiting for the missing word
	} cache_state_e;

endpackage

//--- verilog/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// width of one address tag
`define CACHE_ADDR_W 8

// width of one data word
`define CACHE_DATA_W 16

// number of lines in the fully associative array
`define CACHE_LINES 4

// the usage counter is wide enough that it does not drain during a normal run
`define CACHE_AGE_W 16

`endif

//--- verilog/cache_types_pkg.sv
`include "cache_defines.svh"

package cache_types_pkg;

	// address tag as seen by the host and the backing store
	typedef logic [`CACHE_ADDR_W-1:0] addr_t;

	// one cached data word
	typedef logic [`CACHE_DATA_W-1:0] data_t;

	// index of one line in the array
	typedef logic [$clog2(`CACHE_LINES)-1:0] line_idx_t;

	// a larger age means the line was used more recently
	typedef logic [`CACHE_AGE_W-1:0] age_t;

	// ages of all lines where element i belongs to line i
	typedef age_t [`CACHE_LINES-1:0] age_vec_t;

endpackage

//--- verilog/line_store.sv
`include "cache_defines.svh"

module line_store (
	input  logic                      clk,
	input  logic                      rst_n,
	input  cache_types_pkg::addr_t    lookup_addr,
	input  cache_types_pkg::data_t    wdata,
	input  cache_types_pkg::data_t    fill_data,
	input  logic                      wr_en,
	input  logic                      fill_en,
	input  logic                      inval_en,
	input  cache_types_pkg::line_idx_t victim_idx,
	output logic                      hit,
	output cache_types_pkg::line_idx_t hit_idx,
	output cache_types_pkg::data_t    rdata,
	output logic                      has_free,
	output cache_types_pkg::line_idx_t free_idx,
	output cache_types_pkg::addr_t    victim_addr,
	output cache_types_pkg::data_t    victim_data
);
	import cache_types_pkg::*;

	logic [`CACHE_LINES-1:0] valid;
	logic [`CACHE_LINES-1:0] match;
	addr_t                   tag [`CACHE_LINES];
	data_t                   data [`CACHE_LINES];

	// tags are unique among valid lines, so at most one match bit is set
	always_comb begin
		for (int i = 0; i < `CACHE_LINES; i++) begin
			match[i] = valid[i] && (tag[i] == lookup_addr);
		end
	end

	assign hit      = |match;
	assign has_free = ~&valid;

	// walking down from the top leaves the lowest matching or free index
	always_comb begin
		hit_idx  = '0;
		free_idx = '0;
		for (int i = `CACHE_LINES - 1; i >= 0; i--) begin
			if (match[i]) begin
				hit_idx = line_idx_t'(i);
			end
			if (!valid[i]) begin
				free_idx = line_idx_t'(i);
			end
		end
	end

	assign rdata       = data[hit_idx];
	assign victim_addr = tag[victim_idx];	// evicted line goes out as tag and data
	assign victim_data = data[victim_idx];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else begin
			if (fill_en) begin
				valid[free_idx] <= 1'b1;
			end
			if (inval_en) begin
				valid[victim_idx] <= 1'b0;
			end
		end
	end

	// a fill takes the lookup address as its tag, a write only touches the data
	always_ff @(posedge clk) begin
		if (fill_en) begin
			tag[free_idx]  <= lookup_addr;
			data[free_idx] <= fill_data;
		end else if (wr_en) begin
			data[hit_idx] <= wdata;
		end
	end

endmodule

//--- verilog/victim_scan.sv
`include "cache_defines.svh"

module victim_scan (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       scan_start,
	input  cache_types_pkg::age_vec_t  ages,
	output cache_types_pkg::line_idx_t victim_idx,
	output logic                       scan_done
);
	import cache_types_pkg::*;

	localparam line_idx_t last_idx = line_idx_t'(`CACHE_LINES - 1);

	logic      busy;
	line_idx_t iter;
	line_idx_t min_idx;

	assign scan_done  = busy && (iter == last_idx);
	assign victim_idx = min_idx;

	// both ages are read live, so the common countdown cancels out of the compare
	// a strict compare keeps the lower index on a tie
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			iter    <= '0;
			min_idx <= '0;
		end else if (scan_start) begin
			busy    <= 1'b1;
			iter    <= '0;
			min_idx <= '0;
		end else if (busy) begin
			if (ages[iter] < ages[min_idx]) begin
				min_idx <= iter;
			end
			if (scan_done) begin
				busy <= 1'b0;	// victim_idx holds from here until the next scan
			end else begin
				iter <= iter + 1'b1;
			end
		end
	end

endmodule
